/* bit_decoder.f */
rtl/dec_cfg_pkg.sv
rtl/dec_stream_pkg.sv
rtl/pipe_reg.sv
rtl/dec_regs.sv
rtl/biphase_stage.sv
rtl/mark_space_stage.sv
rtl/iq_serializer.sv
rtl/derand_stage.sv
rtl/bit_decoder.sv
dv/bit_decoder_checker.sv
dv/bit_decoder_tb.sv

/* Makefile */
# Verilator build and run of the bit decoder testbench

TOP := bit_decoder_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f bit_decoder.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* dv/bit_decoder_tb.sv */
// directed testbench for the bit decoder, random symbols and output stalls
// a task-based model queues the expected beats, each test checks them in order
`timescale 1ns/100ps

module bit_decoder_tb
  import dec_cfg_pkg::*;
  import dec_stream_pkg::*;
();

  localparam int unsigned REG_ADDR_W    = 4;
  localparam logic [3:0]  REG_BASE      = 4'h8;
  localparam logic [3:0]  CTRL_ADDR     = REG_BASE + 4'(CTRL_OFS);
  localparam logic [3:0]  STATUS_ADDR   = REG_BASE + 4'(STATUS_OFS);
  localparam logic [3:0]  UNMAPPED_ADDR = REG_BASE + 4'd5;

  // symbols per test, biphase sends two halves per pair
  localparam int N_PASS      = 64;
  localparam int N_DIFF      = 48;
  localparam int N_PAIRS     = 32;
  localparam int N_DEMUX     = 32;
  localparam int N_DERAND    = 64;
  localparam int TOTAL_SYMS  = N_PASS + 2 * N_DIFF + 4 * N_PAIRS + 2 * N_DEMUX + 2 * N_DERAND;
  // 20 periods per symbol, margin for resets and register traffic
  localparam int WATCHDOG_NS = 20 * TOTAL_SYMS * 4 + 4000;

  logic        clk = 1'b0;
  logic        rs;
  logic        sym_valid_i;
  logic        sym_ready_o;
  iq_sym_t     sym_i;
  logic        out_valid_o;
  logic        out_ready_i;
  bit_pair_t   out_o;
  logic        reg_wr_i;
  logic [3:0]  reg_addr_i;
  logic [15:0] reg_wdata_i;
  logic [15:0] reg_rdata_o;

  // model state
  dec_ctrl_t   cur_ctrl;   // last written control word, reserved bits cleared
  iq_sym_t     ms_prev;    // previous nrz symbol per rail
  logic [15:1] rx_dly;     // rx_dly[k] is lane i received k beats back
  logic        err_exp;    // a bad biphase pair went in
  iq_sym_t     tx_q[$];
  bit_pair_t   exp_q[$];

  integer      seed = 32'h9164_b77c;
  logic [31:0] rnd;
  int          errors   = 0;
  int          checks   = 0;
  int          tests    = 0;
  int          err_mark = 0;

  bit_decoder #(
    .REG_ADDR_W (REG_ADDR_W),
    .REG_BASE   (REG_BASE)
  ) u_dut (
    .clk         (clk),
    .rs          (rs),
    .sym_valid_i (sym_valid_i),
    .sym_ready_o (sym_ready_o),
    .sym_i       (sym_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_o       (out_o),
    .reg_wr_i    (reg_wr_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o)
  );

  // 4 ns period
  always #2 clk = ~clk;

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the stream stopped moving", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  // -------------------------------------------------------------------------
  // compare and bookkeeping
  // -------------------------------------------------------------------------

  task automatic check_pair(input string name, input bit_pair_t exp, input bit_pair_t act);
    checks = checks + 1;
    if (act !== exp)
    begin
      errors = errors + 1;
      $display("** Error [%s] expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks = checks + 1;
    if (act !== exp)
    begin
      errors = errors + 1;
      $display("** Error [%s] expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic begin_test();
    err_mark = errors;
  endtask

  task automatic end_test(input string name);
    tests = tests + 1;
    if (errors == err_mark)
    begin
      $display("test %-10s done, no errors", name);
    end
    else
    begin
      $display("test %-10s done, %0d errors", name, errors - err_mark);
    end
  endtask

  // -------------------------------------------------------------------------
  // reset and register bus
  // -------------------------------------------------------------------------

  task automatic apply_reset();
    rs = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rs       = 1'b0;
    cur_ctrl = '0;
    ms_prev  = '0;
    rx_dly   = '0;
    err_exp  = 1'b0;
  endtask

  task automatic reg_write(input logic [3:0] addr, input logic [15:0] data);
    @(posedge clk);
    #1;
    reg_wr_i    = 1'b1;
    reg_addr_i  = addr;
    reg_wdata_i = data;
    @(posedge clk);
    #1;
    reg_wr_i    = 1'b0;
  endtask

  // data is registered, one cycle behind the address
  task automatic reg_read(input logic [3:0] addr, output logic [15:0] data);
    @(posedge clk);
    #1;
    reg_addr_i = addr;
    @(posedge clk);
    #1;
    data = reg_rdata_o;
  endtask

  task automatic set_ctrl(input dec_ctrl_t c);
    reg_write(CTRL_ADDR, c);
    cur_ctrl      = c;
    cur_ctrl.rsvd = '0;
  endtask

  // -------------------------------------------------------------------------
  // reference model
  // -------------------------------------------------------------------------

  function automatic bit_pair_t make_pair(input logic i, input logic q);
    bit_pair_t p;
    p.i = i;
    p.q = q;
    return p;
  endfunction

  // derandomize, invert, queue one output beat
  task automatic push_beat(input bit_pair_t rx);
    bit_pair_t o;
    logic      d;
    o = rx;
    // 1 + x^14 + x^15, received bit against its 14th and 15th predecessor
    d = rx.i ^ rx_dly[14] ^ rx_dly[15];
    if (cur_ctrl.derand_en)
    begin
      o = make_pair(d, d);
    end
    if (cur_ctrl.invert)
    begin
      o = make_pair(~o.i, ~o.q);
    end
    rx_dly = {rx_dly[14:1], rx.i};
    exp_q.push_back(o);
  endtask

  // one nrz symbol after biphase folding
  task automatic model_symbol(input iq_sym_t s);
    iq_sym_t d;
    logic    first;
    logic    second;
    d = s;
    if (cur_ctrl.mode == CODE_NRZ_M)
    begin
      // level change means one
      d.i = (s.i != ms_prev.i);
      d.q = (s.q != ms_prev.q);
    end
    else if (cur_ctrl.mode == CODE_NRZ_S)
    begin
      // level held means one
      d.i = (s.i == ms_prev.i);
      d.q = (s.q == ms_prev.q);
    end
    ms_prev = s;
    if (cur_ctrl.demux_en)
    begin
      first  = cur_ctrl.swap ? d.q : d.i;
      second = cur_ctrl.swap ? d.i : d.q;
      push_beat(make_pair(first, first));
      push_beat(make_pair(second, second));
    end
    else
    begin
      push_beat(make_pair(d.i, d.q));
    end
  endtask

  task automatic load_random(input int n);
    iq_sym_t s;
    for (int k = 0; k < n; k++)
    begin
      rnd = $random(seed);
      s   = iq_sym_t'(rnd[1:0]);
      tx_q.push_back(s);
      model_symbol(s);
    end
  endtask

  // biphase-l pairs, pair bad_at gets equal halves on the q rail
  task automatic load_pairs(input int n, input int bad_at);
    iq_sym_t h1;
    iq_sym_t h2;
    for (int k = 0; k < n; k++)
    begin
      rnd = $random(seed);
      h1  = iq_sym_t'(rnd[1:0]);
      h2  = iq_sym_t'(~rnd[1:0]);
      if (k == bad_at)
      begin
        h2.q    = h1.q;
        err_exp = 1'b1;
      end
      tx_q.push_back(h1);
      tx_q.push_back(h2);
      model_symbol(h1);
    end
  endtask

  // -------------------------------------------------------------------------
  // stream driver and monitor, one process
  // -------------------------------------------------------------------------

  task automatic run_stream(input string name, input logic stall);
    int   n_tx;
    int   n_exp;
    int   idx;
    int   got;
    logic taken;
    logic extra;
    n_tx  = tx_q.size();
    n_exp = exp_q.size();
    idx   = 0;
    got   = 0;
    taken = 1'b0;
    extra = 1'b0;
    while (got < n_exp)
    begin
      @(posedge clk);
      #1;
      rnd = $random(seed);
      if (taken)
      begin
        sym_valid_i = 1'b0;
        taken       = 1'b0;
      end
      // idle gap about one cycle in four
      if (!sym_valid_i && idx < n_tx && rnd[3:2] != 2'b00)
      begin
        sym_valid_i = 1'b1;
        sym_i       = tx_q[idx];
      end
      out_ready_i = stall ? (rnd[1:0] != 2'b00) : 1'b1;
      // mid-cycle sample, transfer happens on the next rising edge
      @(negedge clk);
      if (sym_valid_i && sym_ready_o)
      begin
        idx   = idx + 1;
        taken = 1'b1;
      end
      if (out_valid_o && out_ready_i)
      begin
        check_pair(name, exp_q.pop_front(), out_o);
        got = got + 1;
      end
    end
    @(posedge clk);
    #1;
    sym_valid_i = 1'b0;
    out_ready_i = 1'b1;
    if (idx != n_tx)
    begin
      errors = errors + 1;
      $display("[%s] only %0d of %0d symbols were accepted", name, idx, n_tx);
    end
    // pipeline must be empty now
    repeat (4)
    begin
      @(negedge clk);
      extra = extra | out_valid_o;
    end
    if (extra)
    begin
      errors = errors + 1;
      $display("[%s] output beat seen after the expected stream ended", name);
    end
    tx_q.delete();
  endtask

  // -------------------------------------------------------------------------
  // directed tests
  // -------------------------------------------------------------------------

  task automatic test_regs();
    dec_ctrl_t   c;
    dec_status_t st;
    logic [15:0] rd;
    begin_test();
    c  = '0;
    st = '0;
    reg_read(CTRL_ADDR, rd);
    check_reg("regs", c, rd);
    reg_read(STATUS_ADDR, rd);
    check_reg("regs", st, rd);
    // reserved field must come back zero
    c = dec_ctrl_t'(16'hffff);
    reg_write(CTRL_ADDR, c);
    c.rsvd = '0;
    reg_read(CTRL_ADDR, rd);
    check_reg("regs", c, rd);
    reg_read(UNMAPPED_ADDR, rd);
    check_reg("regs", 16'h0000, rd);
    set_ctrl('0);
    end_test("regs");
  endtask

  task automatic test_passthrough();
    dec_ctrl_t c;
    begin_test();
    c = '0;
    set_ctrl(c);
    load_random(N_PASS);
    run_stream("nrz_l", 1'b1);
    end_test("nrz_l");
  endtask

  task automatic test_diff();
    dec_ctrl_t c;
    begin_test();
    // history back to zero
    apply_reset();
    c      = '0;
    c.mode = CODE_NRZ_M;
    set_ctrl(c);
    load_random(N_DIFF);
    run_stream("nrz_m", 1'b1);
    c.mode = CODE_NRZ_S;
    set_ctrl(c);
    load_random(N_DIFF);
    run_stream("nrz_s", 1'b1);
    end_test("nrz_m_s");
  endtask

  task automatic test_biphase();
    dec_ctrl_t   c;
    dec_status_t st;
    logic [15:0] rd;
    begin_test();
    c            = '0;
    c.biphase_en = 1'b1;
    set_ctrl(c);
    st = '0;
    load_pairs(N_PAIRS, -1);
    run_stream("biphase", 1'b1);
    st.code_err = err_exp;
    reg_read(STATUS_ADDR, rd);
    check_reg("biphase", st, rd);
    // one pair with a missing mid-symbol transition
    load_pairs(N_PAIRS, N_PAIRS / 2);
    run_stream("biphase", 1'b1);
    st.code_err = err_exp;
    reg_read(STATUS_ADDR, rd);
    check_reg("biphase", st, rd);
    reg_write(STATUS_ADDR, 16'h0000);
    err_exp     = 1'b0;
    st.code_err = err_exp;
    reg_read(STATUS_ADDR, rd);
    check_reg("biphase", st, rd);
    end_test("biphase");
  endtask

  task automatic test_demux();
    dec_ctrl_t c;
    begin_test();
    c          = '0;
    c.demux_en = 1'b1;
    set_ctrl(c);
    load_random(N_DEMUX);
    // output always ready, the serializer alone throttles the input
    run_stream("demux", 1'b0);
    c.swap = 1'b1;
    set_ctrl(c);
    load_random(N_DEMUX);
    run_stream("demux_swap", 1'b1);
    end_test("demux");
  endtask

  task automatic test_derand();
    dec_ctrl_t c;
    begin_test();
    // lfsr history from reset
    apply_reset();
    c           = '0;
    c.derand_en = 1'b1;
    set_ctrl(c);
    load_random(N_DERAND);
    run_stream("derand", 1'b1);
    c.invert   = 1'b1;
    c.demux_en = 1'b1;
    set_ctrl(c);
    load_random(N_DERAND);
    run_stream("derand_inv", 1'b1);
    end_test("derand");
  endtask

  // -------------------------------------------------------------------------
  // main sequence
  // -------------------------------------------------------------------------

  initial
  begin
    rs          = 1'b1;
    sym_valid_i = 1'b0;
    sym_i       = '0;
    out_ready_i = 1'b1;
    reg_wr_i    = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    apply_reset();
    test_regs();
    test_passthrough();
    test_diff();
    test_biphase();
    test_demux();
    test_derand();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* dv/bit_decoder_checker.sv */
// stream protocol assertions for the bit decoder ports
// bound into every bit_decoder instance
`timescale 1ns/100ps

module bit_decoder_checker
  import dec_stream_pkg::*;
(
  input logic      clk,
  input logic      rs,
  input logic      sym_ready_i,
  input logic      out_valid_i,
  input logic      out_ready_i,
  input bit_pair_t out_i
);

  // stalled beat stays put until taken
  stall_hold_a : assert property (@(posedge clk) disable iff (rs)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_i))
  else $error("output beat changed or vanished while stalled");

  // skid entries empty, nothing to send
  reset_state_a : assert property (@(posedge clk)
    $fell(rs) |-> sym_ready_i && !out_valid_i)
  else $error("stream ports not idle in first cycle after reset");

  // no x or z on a valid beat
  known_data_a : assert property (@(posedge clk) disable iff (rs)
    out_valid_i |-> !$isunknown(out_i))
  else $error("unknown bits on a valid output beat");

endmodule

bind bit_decoder bit_decoder_checker u_checker (
  .clk         (clk),
  .rs          (rs),
  .sym_ready_i (sym_ready_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_i       (out_o)
);

/* rtl/bit_decoder.sv */
// bit-decoding back end: biphase, mark/space, i/q demux, derandomizer
// symbols in on a valid/ready stream, decoded bits out, control over the register bus
`timescale 1ns/100ps

module bit_decoder
  import dec_cfg_pkg::*;
  import dec_stream_pkg::*;
#(
  parameter int unsigned           REG_ADDR_W = 4,
  parameter logic [REG_ADDR_W-1:0] REG_BASE   = '0
) (
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  sym_valid_i,
  output logic                  sym_ready_o,
  input  iq_sym_t               sym_i,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output bit_pair_t             out_o,
  input  logic                  reg_wr_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [15:0]           reg_wdata_i,
  output logic [15:0]           reg_rdata_o
);

  dec_ctrl_t ctrl;
  logic      code_err;
  // stage links
  logic      nrz_valid;
  logic      nrz_ready;
  iq_sym_t   nrz;
  logic      ms_valid;
  logic      ms_ready;
  iq_sym_t   ms;
  logic      ser_valid;
  logic      ser_ready;
  bit_pair_t ser;

  // -------------------------------------------------------------------------
  // register bank
  // -------------------------------------------------------------------------

  dec_regs #(
    .REG_ADDR_W (REG_ADDR_W),
    .REG_BASE   (REG_BASE)
  ) u_regs (
    .clk         (clk),
    .rs          (rs),
    .reg_wr_i    (reg_wr_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .code_err_i  (code_err),
    .ctrl_o      (ctrl)
  );

  // -------------------------------------------------------------------------
  // decode chain, one skid register per stage
  // -------------------------------------------------------------------------

  biphase_stage u_biphase (
    .clk (clk), .rs (rs), .ctrl_i (ctrl),
    .sym_valid_i (sym_valid_i), .sym_ready_o (sym_ready_o), .sym_i (sym_i),
    .nrz_valid_o (nrz_valid), .nrz_ready_i (nrz_ready), .nrz_o (nrz),
    .code_err_o  (code_err)
  );

  mark_space_stage u_mark_space (
    .clk (clk), .rs (rs), .ctrl_i (ctrl),
    .in_valid_i  (nrz_valid), .in_ready_o (nrz_ready), .in_i (nrz),
    .out_valid_o (ms_valid), .out_ready_i (ms_ready), .out_o (ms)
  );

  iq_serializer u_serializer (
    .clk (clk), .rs (rs), .ctrl_i (ctrl),
    .in_valid_i  (ms_valid), .in_ready_o (ms_ready), .in_i (ms),
    .out_valid_o (ser_valid), .out_ready_i (ser_ready), .out_o (ser)
  );

  derand_stage u_derand (
    .clk (clk), .rs (rs), .ctrl_i (ctrl),
    .in_valid_i  (ser_valid), .in_ready_o (ser_ready), .in_i (ser),
    .out_valid_o (out_valid_o), .out_ready_i (out_ready_i), .out_o (out_o)
  );

endmodule

/* rtl/derand_stage.sv */
// self-synchronizing derandomizer, 1 + x^14 + x^15, then optional inversion
// last stage of the chain
`timescale 1ns/100ps

module derand_stage
  import dec_cfg_pkg::*;
  import dec_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rs,
  input  dec_ctrl_t ctrl_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  bit_pair_t in_i,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output bit_pair_t out_o
);

  logic [14:0] hist_q;   // received bits, newest in bit 0
  logic        derand_bit;
  logic        pipe_ready;
  bit_pair_t   res;

  assign in_ready_o = pipe_ready;

  // taps from the history before this beat shifts in
  assign derand_bit = in_i.i ^ hist_q[14] ^ hist_q[13];

  // keeps running with derand off so it is in sync when enabled
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      hist_q <= '0;
    end
    else if (in_valid_i && pipe_ready)
    begin
      hist_q <= {hist_q[13:0], in_i.i};
    end
  end

  always_comb
  begin
    res = in_i;
    if (ctrl_i.derand_en)
    begin
      res.i = derand_bit;
      res.q = derand_bit;
    end
    if (ctrl_i.invert)
    begin
      res.i = ~res.i;
      res.q = ~res.q;
    end
  end

  pipe_reg #(
    .payload_t (bit_pair_t)
  ) u_pipe (
    .clk         (clk),
    .rs          (rs),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (pipe_ready),
    .in_data_i   (res),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_o)
  );

endmodule

/* rtl/iq_serializer.sv */
// qpsk/oqpsk demux, turns each i/q symbol into one parallel beat or two serial
// beats; swap puts q first
`timescale 1ns/100ps

module iq_serializer
  import dec_cfg_pkg::*;
  import dec_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rs,
  input  dec_ctrl_t ctrl_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  iq_sym_t   in_i,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output bit_pair_t out_o
);

  logic      phase_q;    // second bit pending
  logic      second_q;
  logic      first_bit;
  logic      second_bit;
  logic      in_fire;
  logic      pipe_valid;
  logic      pipe_ready;
  bit_pair_t pipe_data;

  assign first_bit  = ctrl_i.swap ? in_i.q : in_i.i;
  assign second_bit = ctrl_i.swap ? in_i.i : in_i.q;

  // symbol consumed with its first bit, input blocked during the second
  assign in_ready_o = ~phase_q & pipe_ready;
  assign in_fire    = in_valid_i & in_ready_o;
  assign pipe_valid = phase_q | in_valid_i;

  always_comb
  begin
    if (phase_q)
    begin
      pipe_data.i = second_q;
      pipe_data.q = second_q;
    end
    else if (ctrl_i.demux_en)
    begin
      pipe_data.i = first_bit;
      pipe_data.q = first_bit;
    end
    else
    begin
      // parallel pair
      pipe_data.i = in_i.i;
      pipe_data.q = in_i.q;
    end
  end

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      phase_q <= 1'b0;
    end
    else if (phase_q)
    begin
      if (pipe_ready)
      begin
        phase_q <= 1'b0;
      end
    end
    else if (in_fire && ctrl_i.demux_en)
    begin
      phase_q <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (in_fire)
    begin
      second_q <= second_bit;
    end
  end

  pipe_reg #(
    .payload_t (bit_pair_t)
  ) u_pipe (
    .clk         (clk),
    .rs          (rs),
    .in_valid_i  (pipe_valid),
    .in_ready_o  (pipe_ready),
    .in_data_i   (pipe_data),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_o)
  );

endmodule

/* rtl/mark_space_stage.sv */
// nrz-l / nrz-m / nrz-s decoding, each rail against its own previous bit
`timescale 1ns/100ps

module mark_space_stage
  import dec_cfg_pkg::*;
  import dec_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rs,
  input  dec_ctrl_t ctrl_i,
  input  logic      in_valid_i,
  output logic      in_ready_o,
  input  iq_sym_t   in_i,
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output iq_sym_t   out_o
);

  iq_sym_t prev_q;   // last accepted input, per rail
  iq_sym_t dec;
  logic    pipe_ready;

  assign in_ready_o = pipe_ready;

  // history moves on every accepted beat, whatever the mode
  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      prev_q <= '0;
    end
    else if (in_valid_i && pipe_ready)
    begin
      prev_q <= in_i;
    end
  end

  // mark: transition means one, space: transition means zero
  always_comb
  begin
    case (ctrl_i.mode)
      CODE_NRZ_M:
      begin
        dec.i = in_i.i ^ prev_q.i;
        dec.q = in_i.q ^ prev_q.q;
      end
      CODE_NRZ_S:
      begin
        dec.i = ~(in_i.i ^ prev_q.i);
        dec.q = ~(in_i.q ^ prev_q.q);
      end
      default:
      begin
        dec = in_i;
      end
    endcase
  end

  pipe_reg #(
    .payload_t (iq_sym_t)
  ) u_pipe (
    .clk         (clk),
    .rs          (rs),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (pipe_ready),
    .in_data_i   (dec),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_o)
  );

endmodule

/* rtl/biphase_stage.sv */
// first decoder stage, folds biphase-l half-symbol pairs into nrz symbols
// passes symbols straight on when biphase is off
`timescale 1ns/100ps

module biphase_stage
  import dec_cfg_pkg::*;
  import dec_stream_pkg::*;
(
  input  logic      clk,
  input  logic      rs,
  input  dec_ctrl_t ctrl_i,
  input  logic      sym_valid_i,
  output logic      sym_ready_o,
  input  iq_sym_t   sym_i,
  output logic      nrz_valid_o,
  input  logic      nrz_ready_i,
  output iq_sym_t   nrz_o,
  output logic      code_err_o
);

  logic    phase_q;     // first half held, waiting for second
  iq_sym_t half_q;
  logic    first_half;
  logic    sym_fire;
  logic    pair_bad;
  logic    pipe_valid;
  logic    pipe_ready;
  iq_sym_t pipe_data;

  // first half of a pair only gets stored
  assign first_half = ctrl_i.biphase_en & ~phase_q;

  // first halves always taken, otherwise wait on the skid register
  assign sym_ready_o = first_half | pipe_ready;
  assign sym_fire    = sym_valid_i & sym_ready_o;

  // a valid biphase pair toggles mid-symbol on both rails
  assign pair_bad   = (half_q.i == sym_i.i) | (half_q.q == sym_i.q);
  assign code_err_o = sym_fire & ctrl_i.biphase_en & phase_q & pair_bad;

  // bit is the first half, even for a bad pair
  assign pipe_valid = sym_valid_i & ~first_half;
  assign pipe_data  = ctrl_i.biphase_en ? half_q : sym_i;

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      phase_q <= 1'b0;
    end
    else if (!ctrl_i.biphase_en)
    begin
      phase_q <= 1'b0;
    end
    else if (sym_fire)
    begin
      phase_q <= ~phase_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sym_fire && first_half)
    begin
      half_q <= sym_i;
    end
  end

  pipe_reg #(
    .payload_t (iq_sym_t)
  ) u_pipe (
    .clk         (clk),
    .rs          (rs),
    .in_valid_i  (pipe_valid),
    .in_ready_o  (pipe_ready),
    .in_data_i   (pipe_data),
    .out_valid_o (nrz_valid_o),
    .out_ready_i (nrz_ready_i),
    .out_data_o  (nrz_o)
  );

endmodule

/* rtl/dec_regs.sv */
// control word and sticky status word on a simple register bus
// reads are registered, data appears one cycle after the address
`timescale 1ns/100ps

module dec_regs
  import dec_cfg_pkg::*;
#(
  parameter int unsigned                REG_ADDR_W = 4,
  parameter logic [REG_ADDR_W-1:0]      REG_BASE   = '0
) (
  input  logic                  clk,
  input  logic                  rs,
  input  logic                  reg_wr_i,
  input  logic [REG_ADDR_W-1:0] reg_addr_i,
  input  logic [15:0]           reg_wdata_i,
  output logic [15:0]           reg_rdata_o,
  input  logic                  code_err_i,
  output dec_ctrl_t             ctrl_o
);

  // absolute addresses of the two words
  localparam logic [REG_ADDR_W-1:0] CTRL_ADDR   = REG_BASE + REG_ADDR_W'(CTRL_OFS);
  localparam logic [REG_ADDR_W-1:0] STATUS_ADDR = REG_BASE + REG_ADDR_W'(STATUS_OFS);

  dec_ctrl_t   ctrl_q;
  dec_ctrl_t   ctrl_wdata;
  dec_status_t status_q;
  logic        ctrl_hit;
  logic        status_hit;
  logic [15:0] rdata_next;
  logic [15:0] rdata_q;

  assign ctrl_hit   = (reg_addr_i == CTRL_ADDR);
  assign status_hit = (reg_addr_i == STATUS_ADDR);

  // write data with reserved field forced low
  always_comb
  begin
    ctrl_wdata      = dec_ctrl_t'(reg_wdata_i);
    ctrl_wdata.rsvd = '0;
  end

  // -------------------------------------------------------------------------
  // control and status storage
  // -------------------------------------------------------------------------

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      ctrl_q   <= '0;
      status_q <= '0;
    end
    else
    begin
      if (reg_wr_i && ctrl_hit)
      begin
        ctrl_q <= ctrl_wdata;
      end
      // new error beats a clearing write
      if (code_err_i)
      begin
        status_q.code_err <= 1'b1;
      end
      else if (reg_wr_i && status_hit)
      begin
        status_q <= '0;
      end
    end
  end

  // -------------------------------------------------------------------------
  // readback
  // -------------------------------------------------------------------------

  // unmapped addresses read zero
  always_comb
  begin
    rdata_next = '0;
    if (ctrl_hit)
    begin
      rdata_next = ctrl_q;
    end
    else if (status_hit)
    begin
      rdata_next = status_q;
    end
  end

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      rdata_q <= '0;
    end
    else
    begin
      rdata_q <= rdata_next;
    end
  end

  assign reg_rdata_o = rdata_q;
  assign ctrl_o      = ctrl_q;

endmodule

/* rtl/pipe_reg.sv */
// two-entry valid/ready skid register, closes every decoder stage
// ready comes straight from a flop so no stage sees downstream ready combinationally
`timescale 1ns/100ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rs,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     out_valid_q;
  logic     skid_valid_q;
  payload_t out_data_q;
  payload_t skid_data_q;
  logic     in_fire;
  logic     out_free;

  // skid empty means room for one more beat
  assign in_ready_o = ~skid_valid_q;
  assign in_fire    = in_valid_i & ~skid_valid_q;
  // output slot empty or leaving this cycle
  assign out_free   = ~out_valid_q | out_ready_i;

  always_ff @(posedge clk or posedge rs)
  begin
    if (rs)
    begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end
    else if (out_free)
    begin
      // skid drains first, keeps order
      out_valid_q  <= skid_valid_q | in_fire;
      skid_valid_q <= 1'b0;
    end
    else if (in_fire)
    begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (out_free)
    begin
      if (skid_valid_q)
      begin
        out_data_q <= skid_data_q;
      end
      else if (in_fire)
      begin
        out_data_q <= in_data_i;
      end
    end
    else if (in_fire)
    begin
      skid_data_q <= in_data_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;

endmodule

/* rtl/dec_stream_pkg.sv */
// beat payloads carried on the valid/ready links between decoder stages
// imported by the stages and by the top level
package dec_stream_pkg;

  // -------------------------------------------------------------------------
  // stream payloads
  // -------------------------------------------------------------------------

  // one hard-decision symbol, both rails
  typedef struct packed {
    logic i;
    logic q;
  } iq_sym_t;

  // one output beat
  // in serial mode both lanes carry the same bit
  typedef struct packed {
    logic i;
    logic q;
  } bit_pair_t;

endpackage

/* rtl/dec_cfg_pkg.sv */
// control/status register layouts and bus offsets of the bit decoder
// imported by the register bank and by every stage that reads the control word
package dec_cfg_pkg;

  // -------------------------------------------------------------------------
  // code selection
  // -------------------------------------------------------------------------

  // value 3 unused, decodes as nrz-l
  typedef enum logic [1:0] {
    CODE_NRZ_L = 2'd0,
    CODE_NRZ_M = 2'd1,
    CODE_NRZ_S = 2'd2
  } code_mode_e;

  // -------------------------------------------------------------------------
  // register layouts
  // -------------------------------------------------------------------------

  // control word, msb first
  typedef struct packed {
    logic [8:0] rsvd;       // reads back as zero
    logic       invert;     // complement final output
    logic       derand_en;  // 1 + x^14 + x^15 derandomizer
    logic       swap;       // q first in serial mode
    logic       demux_en;   // serialize i/q pair
    logic       biphase_en; // biphase-l input
    code_mode_e mode;
  } dec_ctrl_t;

  // status word, sticky bits
  typedef struct packed {
    logic [14:0] rsvd;
    logic        code_err;  // biphase pair with equal halves seen
  } dec_status_t;

  // word offsets from the bank base
  localparam int unsigned CTRL_OFS   = 0;
  localparam int unsigned STATUS_OFS = 1;

endpackage
